// File: design/rvConsts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// first fetch address
`define RESET_PC    32'h0000_0000

// major opcodes of the supported subset
`define OP_RTYPE    7'b0110011
`define OP_ITYPE    7'b0010011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111

// funct3 values
`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_WORD     3'b010
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

// funct7 that turns add into sub
`define F7_SUB      7'b0100000

// ALU operation codes
`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_XOR     3'd4
`define ALU_SLT     3'd5

`endif

// File: design/rvPkg.sv
package rvPkg;

    // data or address word
    typedef logic [31:0] word_t;

    // register index, x0 to x31
    typedef logic [4:0] regIdx_t;

    // ALU operation, values come from the ALU_* macros
    typedef logic [2:0] aluOp_t;

    // sequencer states of the multi-cycle core
    //   FETCH   instruction read on the bus
    //   EXECUTE one cycle of decode, ALU and writeback
    //   MEMORY  data read or write for LW/SW
    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        MEMORY
    } coreState_t;

endpackage

// File: design/rvDecoder.sv
`timescale 1ns/1ps
`include "rvConsts.svh"

module rvDecoder
    import rvPkg::*;
(
    input  word_t   instr,
    output regIdx_t rs1,
    output regIdx_t rs2,
    output regIdx_t rd,
    output word_t   imm,
    output aluOp_t  aluOp,
    output logic    useImm,
    output logic    isLoad,
    output logic    isStore,
    output logic    isBranch,
    output logic    branchOnNe,
    output logic    isJump,
    output logic    writesReg
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      iImm;
    word_t      sImm;
    word_t      bImm;
    word_t      jImm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // sign-extended immediates, B and J already in bytes
    assign iImm = {{20{instr[31]}}, instr[31:20]};
    assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign bImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign jImm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // anything not matched below only advances the PC
        imm        = iImm;
        aluOp      = `ALU_ADD;
        useImm     = 1'b0;
        isLoad     = 1'b0;
        isStore    = 1'b0;
        isBranch   = 1'b0;
        branchOnNe = 1'b0;
        isJump     = 1'b0;
        writesReg  = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                writesReg = 1'b1;
                case (funct3)
                    `F3_ADD: aluOp = (funct7 == `F7_SUB) ? `ALU_SUB : `ALU_ADD;
                    `F3_SLT: aluOp = `ALU_SLT;
                    `F3_XOR: aluOp = `ALU_XOR;
                    `F3_OR:  aluOp = `ALU_OR;
                    `F3_AND: aluOp = `ALU_AND;
                    default: writesReg = 1'b0;
                endcase
            end
            `OP_ITYPE: begin
                // only ADDI
                useImm    = 1'b1;
                writesReg = (funct3 == `F3_ADD);
            end
            `OP_LOAD: begin
                useImm    = 1'b1;
                isLoad    = (funct3 == `F3_WORD);
                writesReg = (funct3 == `F3_WORD);
            end
            `OP_STORE: begin
                imm     = sImm;
                useImm  = 1'b1;
                isStore = (funct3 == `F3_WORD);
            end
            `OP_BRANCH: begin
                imm        = bImm;
                aluOp      = `ALU_SUB;
                isBranch   = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                branchOnNe = funct3[0];
            end
            `OP_JAL: begin
                imm       = jImm;
                isJump    = 1'b1;
                writesReg = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile
    import rvPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  regIdx_t rs1,
    input  regIdx_t rs2,
    input  regIdx_t rd,
    input  logic    wrEn,
    input  word_t   wrData,
    output word_t   rs1Data,
    output word_t   rs2Data
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rd != 5'd0)) begin
            regs[rd] <= wrData;
        end
    end

    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: design/rvAlu.sv
`timescale 1ns/1ps
`include "rvConsts.svh"

module rvAlu
    import rvPkg::*;
(
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t aluOp,
    output word_t  result,
    output logic   equal
);

    word_t notB;
    word_t sum;
    word_t diff;
    logic  signsDiffer;
    logic  lessThan;

    // subtract as a plus inverted b with carry-in set
    assign notB = ~b;
    assign diff = a + notB + 32'd1;
    assign sum  = a + b;

    // on mixed signs the sign of a decides, otherwise the sign of the difference
    assign signsDiffer = a[31] ^ b[31];
    assign lessThan    = signsDiffer ? a[31] : diff[31];

    // zero flag of a - b
    assign equal = ~|diff;

    always_comb begin
        case (aluOp)
            `ALU_ADD: result = sum;
            `ALU_SUB: result = diff;
            `ALU_AND: result = a & b;
            `ALU_OR:  result = a | b;
            `ALU_XOR: result = a ^ b;
            `ALU_SLT: result = {31'd0, lessThan};
            default:  result = sum;
        endcase
    end

endmodule

// File: design/rvNextPc.sv
`timescale 1ns/1ps

module rvNextPc
    import rvPkg::*;
(
    input  word_t pc,
    input  word_t imm,
    output word_t pcPlus4,
    output word_t branchTarget,
    output word_t jumpTarget
);

    word_t relTarget;

    assign pcPlus4 = pc + 32'd4;

    // B and J immediates are byte offsets from the instruction itself
    assign relTarget = pc + imm;

    assign branchTarget = relTarget;
    assign jumpTarget   = relTarget;

endmodule

// File: design/rvCore.sv
`timescale 1ns/1ps
`include "rvConsts.svh"

module rvCore
    import rvPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  word_t datRd,
    input  logic  ack,
    output logic  cyc,
    output logic  stb,
    output logic  we,
    output word_t adr,
    output word_t datWr
);

    coreState_t state;
    word_t      pc;
    word_t      instr;

    // decoder outputs
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    word_t   imm;
    aluOp_t  aluOp;
    logic    useImm;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
    logic    branchOnNe;
    logic    isJump;
    logic    writesReg;

    // datapath
    word_t rs1Data;
    word_t rs2Data;
    word_t aluB;
    word_t aluResult;
    logic  equal;
    word_t pcPlus4;
    word_t branchTarget;
    word_t jumpTarget;
    word_t nextPc;
    word_t wbData;
    logic  wrEn;

    // sequencing
    logic  memOp;
    logic  fetchDone;
    logic  memDone;
    logic  launchFetch;
    logic  launchMem;
    word_t fetchAdr;

    rvDecoder rvDecoder_i (
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .aluOp      (aluOp),
        .useImm     (useImm),
        .isLoad     (isLoad),
        .isStore    (isStore),
        .isBranch   (isBranch),
        .branchOnNe (branchOnNe),
        .isJump     (isJump),
        .writesReg  (writesReg)
    );

    rvRegFile rvRegFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wrEn    (wrEn),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign aluB = useImm ? imm : rs2Data;

    rvAlu rvAlu_i (
        .a      (rs1Data),
        .b      (aluB),
        .aluOp  (aluOp),
        .result (aluResult),
        .equal  (equal)
    );

    rvNextPc rvNextPc_i (
        .pc           (pc),
        .imm          (imm),
        .pcPlus4      (pcPlus4),
        .branchTarget (branchTarget),
        .jumpTarget   (jumpTarget)
    );

    // branch is taken when the compare disagrees with the BNE flag
    always_comb begin
        if (isJump) begin
            nextPc = jumpTarget;
        end else if (isBranch && (equal != branchOnNe)) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign wbData = isJump ? pcPlus4 : (isLoad ? datRd : aluResult);

    assign memOp     = isLoad | isStore;
    assign fetchDone = (state == FETCH) && cyc && ack;
    assign memDone   = (state == MEMORY) && cyc && ack;

    // LW writes at the data ack, everything else in EXECUTE
    assign wrEn = ((state == EXECUTE) && writesReg && !isLoad) || (memDone && isLoad);

    // a fetch starts straight from EXECUTE, or one idle cycle after a data access
    assign launchFetch = ((state == FETCH) && !cyc) || ((state == EXECUTE) && !memOp);
    assign launchMem   = (state == EXECUTE) && memOp;
    assign fetchAdr    = (state == EXECUTE) ? nextPc : pc;

    assign stb = cyc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= FETCH;
            cyc   <= 1'b0;
            we    <= 1'b0;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                FETCH: begin
                    if (fetchDone) begin
                        cyc   <= 1'b0;
                        state <= EXECUTE;
                    end else if (launchFetch) begin
                        cyc <= 1'b1;
                    end
                end
                EXECUTE: begin
                    cyc <= 1'b1;
                    if (memOp) begin
                        we    <= isStore;
                        state <= MEMORY;
                    end else begin
                        pc    <= nextPc;
                        state <= FETCH;
                    end
                end
                MEMORY: begin
                    if (memDone) begin
                        cyc   <= 1'b0;
                        we    <= 1'b0;
                        pc    <= pcPlus4;
                        state <= FETCH;
                    end
                end
                default: begin
                    cyc   <= 1'b0;
                    state <= FETCH;
                end
            endcase
        end
    end

    // bus payload and instruction register
    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instr <= datRd;
        end
        if (launchFetch) begin
            adr <= fetchAdr;
        end
        if (launchMem) begin
            adr   <= aluResult;
            datWr <= rs2Data;
        end
    end

endmodule

// File: sim/rvRefModel.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// program image, data words at 0x400, register dump at 0x600
word_t progMem [0:1023];
word_t expFetch [$];
word_t expWrAdr [$];
word_t expWrDat [$];
word_t haltAdr;

function automatic word_t fillWord(input int idx);
    return (idx * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
endfunction

function automatic word_t encR(input logic [6:0] f7, input int rs2, input int rs1,
                               input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OP_RTYPE};
endfunction

function automatic word_t encI(input word_t imm, input int rs1, input logic [2:0] f3,
                               input int rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic word_t encS(input word_t imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `OP_STORE};
endfunction

function automatic word_t encB(input word_t imm, input int rs2, input int rs1,
                               input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OP_BRANCH};
endfunction

function automatic word_t encJ(input word_t imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OP_JAL};
endfunction

task automatic buildProgram();
    int pc;
    int kind;
    int skip;
    int remaining;
    word_t r;
    logic [2:0] f3Tab [6];
    logic [6:0] f7Tab [6];
    f3Tab = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
    f7Tab = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00};
    for (int i = 0; i < 1024; i++) begin
        progMem[i] = fillWord(i);
    end
    pc = 0;
    for (int x = 1; x < 16; x++) begin
        r = $urandom;
        progMem[pc] = encI(r, 0, 3'd0, x, `OP_ITYPE);
        pc++;
    end
    for (int i = 0; i < 30; i++) begin
        kind = $urandom % 7;
        remaining = 29 - i;
        skip = $urandom % 3 + 1;
        if (skip > remaining) begin
            skip = remaining;
        end
        r = $urandom;
        case (kind)
            0: begin
                kind = $urandom % 6;
                progMem[pc] = encR(f7Tab[kind], $urandom % 31 + 1, $urandom % 31 + 1,
                                   f3Tab[kind], $urandom % 32);
            end
            1: progMem[pc] = encI(r, $urandom % 32, 3'd0, $urandom % 32, `OP_ITYPE);
            2: progMem[pc] = encS(32'h400 + 4 * ($urandom % 16), $urandom % 32, 0);
            3: progMem[pc] = encI(32'h400 + 4 * ($urandom % 16), 0, 3'b010,
                                  $urandom % 32, `OP_LOAD);
            4: progMem[pc] = encB(4 * (skip + 1), $urandom % 16, $urandom % 16,
                                  {2'b00, r[0]});
            5: progMem[pc] = encJ(4 * (skip + 1), $urandom % 32);
            default: begin
                if (r[0]) begin
                    progMem[pc] = encI(r, $urandom % 32, 3'd0, 0, `OP_ITYPE);
                end else begin
                    progMem[pc] = encR(7'h00, $urandom % 32, $urandom % 32, 3'd0, 0);
                end
            end
        endcase
        pc++;
    end
    for (int x = 0; x < 32; x++) begin
        progMem[pc] = encS(32'h600 + 4 * x, x, 0);
        pc++;
    end
    // jump to itself
    progMem[pc] = encJ(0, 0);
    haltAdr = pc * 4;
endtask

task automatic runModel();
    word_t x [32];
    word_t mem [0:1023];
    word_t pc;
    word_t ins;
    word_t immI;
    word_t immS;
    word_t immB;
    word_t immJ;
    word_t a;
    word_t b;
    int haltSeen;
    int steps;
    mem = progMem;
    x = '{default: '0};
    expFetch.delete();
    expWrAdr.delete();
    expWrDat.delete();
    pc = `RESET_PC;
    haltSeen = 0;
    steps = 0;
    while (haltSeen < 2 && steps < 1000) begin
        expFetch.push_back(pc);
        if (pc == haltAdr) begin
            haltSeen++;
        end
        ins = mem[pc[11:2]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        a = x[ins[19:15]];
        b = x[ins[24:20]];
        pc = pc + 4;
        case (ins[6:0])
            `OP_RTYPE: begin
                case (ins[14:12])
                    3'd0: x[ins[11:7]] = ins[30] ? a - b : a + b;
                    3'd2: x[ins[11:7]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd4: x[ins[11:7]] = a ^ b;
                    3'd6: x[ins[11:7]] = a | b;
                    default: x[ins[11:7]] = a & b;
                endcase
            end
            `OP_ITYPE: x[ins[11:7]] = a + immI;
            `OP_LOAD: x[ins[11:7]] = mem[(a + immI) >> 2];
            `OP_STORE: begin
                mem[(a + immS) >> 2] = b;
                expWrAdr.push_back(a + immS);
                expWrDat.push_back(b);
            end
            `OP_BRANCH: begin
                if ((a == b) != ins[12]) begin
                    pc = pc - 4 + immB;
                end
            end
            default: begin
                x[ins[11:7]] = pc;
                pc = pc - 4 + immJ;
            end
        endcase
        x[0] = '0;
        steps++;
    end
endtask

`endif

// File: sim/rvTb.sv
`timescale 1ns/1ps
`include "rvConsts.svh"

module rvTb
    import rvPkg::*;
;

    localparam int NUM_PROGS   = 4;
    localparam int NUM_RUNS    = 2 * NUM_PROGS;
    localparam int CYCLE_LIMIT = NUM_RUNS * 60 * 10 + NUM_RUNS * 8;

    logic  clk;
    logic  arstN;
    word_t datRd;
    logic  ack;
    logic  cyc;
    logic  stb;
    logic  we;
    word_t adr;
    word_t datWr;

    `include "rvRefModel.svh"

    word_t mem [0:1023];
    word_t actFetch [$];
    word_t actWrAdr [$];
    word_t actWrDat [$];
    word_t savedAdr [$];
    word_t savedDat [$];
    logic  zeroWait;
    logic  pending;
    int    waitLeft;
    int    haltCount;
    int    cycleCount;
    int    testErrors;
    int    passCount;
    int    failCount;

    rvCore rvCore_i (
        .clk   (clk),
        .arstN (arstN),
        .datRd (datRd),
        .ack   (ack),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datWr (datWr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("timeout: the core did not reach its halt loop within %0d cycles",
                     CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // memory answers after 0 to 3 wait states and logs reads below 0x400 as fetches
    always @(posedge clk) begin : memModel
        int w;
        w = 0;
        if (!arstN) begin
            ack     <= 1'b0;
            pending = 1'b0;
        end else if (ack) begin
            ack <= 1'b0;
        end else if (cyc && stb) begin
            w = pending ? waitLeft : (zeroWait ? 0 : $urandom % 4);
            if (w > 0) begin
                pending  = 1'b1;
                waitLeft = w - 1;
            end else begin
                pending = 1'b0;
                ack <= 1'b1;
                if (we) begin
                    mem[adr[11:2]] = datWr;
                    actWrAdr.push_back(adr);
                    actWrDat.push_back(datWr);
                end else begin
                    datRd <= mem[adr[11:2]];
                    if (adr < 32'h400 && haltCount < 2) begin
                        actFetch.push_back(adr);
                        if (adr == haltAdr) begin
                            haltCount++;
                        end
                    end
                end
            end
        end
    end

    task automatic checkValue(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("%s: pass", name);
        end else begin
            failCount++;
            $display("%s: fail with %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic applyReset(input string name);
        @(posedge clk);
        arstN <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            checkValue({name, " cyc in reset"}, 32'd0, {31'd0, cyc});
            checkValue({name, " stb in reset"}, 32'd0, {31'd0, stb});
        end
        @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic runProgram(input string name, input logic noWait);
        // the core keeps looping on the previous halt until reset is applied
        applyReset(name);
        mem = progMem;
        actFetch.delete();
        actWrAdr.delete();
        actWrDat.delete();
        haltCount = 0;
        zeroWait = noWait;
        while (haltCount < 2) begin
            @(posedge clk);
        end
        checkValue({name, " first fetch"}, `RESET_PC, actFetch[0]);
        if (actFetch.size() != expFetch.size()) begin
            $display("%s: %0d instructions fetched where %0d were expected",
                     name, actFetch.size(), expFetch.size());
            testErrors++;
        end
        for (int i = 0; i < actFetch.size() && i < expFetch.size(); i++) begin
            checkValue($sformatf("%s fetch %0d", name, i), expFetch[i], actFetch[i]);
        end
        if (actWrAdr.size() != expWrAdr.size()) begin
            $display("%s: %0d bus writes seen where %0d were expected",
                     name, actWrAdr.size(), expWrAdr.size());
            testErrors++;
        end
        for (int i = 0; i < actWrAdr.size() && i < expWrAdr.size(); i++) begin
            checkValue($sformatf("%s write adr %0d", name, i), expWrAdr[i], actWrAdr[i]);
            checkValue($sformatf("%s write dat %0d", name, i), expWrDat[i], actWrDat[i]);
        end
        finishTest(name);
    endtask

    initial begin
        void'($urandom(80016));
        arstN      = 1'b0;
        ack        = 1'b0;
        datRd      = '0;
        zeroWait   = 1'b0;
        pending    = 1'b0;
        waitLeft   = 0;
        haltCount  = 0;
        cycleCount = 0;
        testErrors = 0;
        passCount  = 0;
        failCount  = 0;
        haltAdr    = '1;
        for (int p = 0; p < NUM_PROGS; p++) begin
            buildProgram();
            runModel();
            runProgram($sformatf("prog%0d_waits", p), 1'b0);
            savedAdr = actWrAdr;
            savedDat = actWrDat;
            runProgram($sformatf("prog%0d_nowait", p), 1'b1);
            // writes must not depend on how long the memory stalls
            if (savedAdr.size() != actWrAdr.size()) begin
                $display("prog%0d_backpressure: write count differs between runs", p);
                testErrors++;
            end
            for (int i = 0; i < savedAdr.size() && i < actWrAdr.size(); i++) begin
                checkValue($sformatf("prog%0d_backpressure adr %0d", p, i),
                           savedAdr[i], actWrAdr[i]);
                checkValue($sformatf("prog%0d_backpressure dat %0d", p, i),
                           savedDat[i], actWrDat[i]);
            end
            finishTest($sformatf("prog%0d_backpressure", p));
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
+incdir+sim
design/rvPkg.sv
design/rvDecoder.sv
design/rvRegFile.sv
design/rvAlu.sv
design/rvNextPc.sv
design/rvCore.sv
sim/rvTb.sv
